// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_processorci
FILELIST ?= sources.f
OBJ_DIR  ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== ctrl_regs.sv ====
`timescale 1ns/10ps

`include "pci_settings.svh"

module ctrl_regs (
    input  logic        clk_core,
    input  logic        arst_n_i,
    input  logic        run_pulse_i,
    input  logic [27:0] run_cycles_i,
    input  logic        halt_pulse_i,
    output logic        core_run_o,
    output logic        core_rst_o,
    output logic [31:0] harness_id_o
);

    localparam logic [27:0] DEFAULT_DELAY = 28'(`PCI_RESET_CYCLES);
    localparam logic [31:0] HARNESS_ID    = `PCI_ID;

    logic        run_q;
    logic [27:0] cnt_q;    // zero when no release is pending
    logic [27:0] load_val;

    assign load_val = (run_cycles_i == 28'h0) ? DEFAULT_DELAY : run_cycles_i;

    always_ff @(posedge clk_core or negedge arst_n_i) begin
        if (!arst_n_i) begin
            run_q <= 1'b0;
            cnt_q <= 28'h0;
        end else if (halt_pulse_i) begin
            // Halt wins over everything, including a pending release
            run_q <= 1'b0;
            cnt_q <= 28'h0;
        end else if (run_pulse_i && !run_q) begin
            cnt_q <= load_val;
        end else if (cnt_q != 28'h0) begin
            cnt_q <= cnt_q - 28'h1;
            if (cnt_q == 28'h1) begin
                run_q <= 1'b1;  // release on expiry
            end
        end
    end

    // Reset and run state move together
    assign core_run_o   = run_q;
    assign core_rst_o   = ~run_q;
    assign harness_id_o = HARNESS_ID;

endmodule

// ==== host_link.sv ====
`timescale 1ns/10ps

module host_link (
    input  logic                clk_core,
    input  logic                arst_n_i,
    input  logic                host_req_i,
    input  pci_pkg::host_cmd_t  host_cmd_i,
    input  logic                core_run_i,
    input  logic [31:0]         harness_id_i,
    input  pci_pkg::wb_rsp_t    wb_rsp_i,
    output logic                host_ack_o,
    output pci_pkg::host_rsp_t  host_rsp_o,
    output logic                run_pulse_o,
    output logic [27:0]         run_cycles_o,
    output logic                halt_pulse_o,
    output pci_pkg::wb_req_t    wb_req_o
);
    import pci_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_EXEC,
        S_WAIT_ACK,
        S_RELEASE
    } state_e;

    state_e    state_q;
    host_cmd_t cmd_q;
    host_rsp_t rsp_q;
    logic      ack_q;
    logic      cyc_q;
    logic      run_pulse_q;
    logic      halt_pulse_q;

    // Command held for the whole transaction
    always_ff @(posedge clk_core) begin
        if (state_q == S_IDLE && host_req_i) begin
            cmd_q <= host_cmd_i;
        end
    end

    always_ff @(posedge clk_core or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= S_IDLE;
            rsp_q        <= '0;
            ack_q        <= 1'b0;
            cyc_q        <= 1'b0;
            run_pulse_q  <= 1'b0;
            halt_pulse_q <= 1'b0;
        end else begin
            run_pulse_q  <= 1'b0;  // strobes last one cycle
            halt_pulse_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (host_req_i) begin
                        state_q <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    state_q <= S_RELEASE;
                    ack_q   <= 1'b1;
                    rsp_q   <= '{data: 32'h0, status: ST_OK};
                    case (cmd_q.word.mem.op)
                        OP_WRITE_MEM, OP_READ_MEM: begin
                            if (core_run_i) begin
                                rsp_q.status <= ST_BUSY;  // memory belongs to the core
                            end else begin
                                ack_q   <= 1'b0;
                                cyc_q   <= 1'b1;
                                state_q <= S_WAIT_ACK;
                            end
                        end
                        OP_RUN:     run_pulse_q  <= 1'b1;
                        OP_HALT:    halt_pulse_q <= 1'b1;
                        OP_READ_ID: rsp_q.data   <= harness_id_i;
                        default:    rsp_q.status <= ST_BAD_OP;
                    endcase
                end
                S_WAIT_ACK: begin
                    if (wb_rsp_i.ack) begin
                        cyc_q   <= 1'b0;
                        ack_q   <= 1'b1;
                        state_q <= S_RELEASE;
                        rsp_q   <= '{data: 32'h0, status: ST_OK};
                        if (cmd_q.word.mem.op == OP_READ_MEM) begin
                            rsp_q.data <= wb_rsp_i.dat;
                        end
                    end else if (core_run_i) begin
                        // Core took the memory before our access was served
                        cyc_q   <= 1'b0;
                        ack_q   <= 1'b1;
                        state_q <= S_RELEASE;
                        rsp_q   <= '{data: 32'h0, status: ST_BUSY};
                    end
                end
                S_RELEASE: begin
                    if (!host_req_i) begin
                        ack_q   <= 1'b0;
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    assign host_ack_o   = ack_q;
    assign host_rsp_o   = rsp_q;
    assign run_pulse_o  = run_pulse_q;
    assign halt_pulse_o = halt_pulse_q;
    assign run_cycles_o = cmd_q.word.ctrl.cycles;

    assign wb_req_o.cyc = cyc_q;
    assign wb_req_o.stb = cyc_q;
    assign wb_req_o.we  = (cmd_q.word.mem.op == OP_WRITE_MEM);
    assign wb_req_o.adr = {14'h0, cmd_q.word.mem.addr, 2'b00};  // word to byte address
    assign wb_req_o.dat = cmd_q.data;
    assign wb_req_o.sel = 4'hF;

endmodule

// ==== native_to_wb.sv ====
`timescale 1ns/10ps

module native_to_wb (
    input  logic             clk_core,
    input  logic             arst_n_i,
    input  logic             mem_valid_i,
    input  logic [31:0]      mem_addr_i,
    input  logic [31:0]      mem_wdata_i,
    input  logic [3:0]       mem_wstrb_i,
    input  pci_pkg::wb_rsp_t wb_rsp_i,
    output logic             mem_ready_o,
    output logic [31:0]      mem_rdata_o,
    output pci_pkg::wb_req_t wb_req_o
);
    import pci_pkg::*;

    logic        pending_q;  // set from request until ready
    logic        cyc_q;
    logic        ready_q;
    logic        we_q;
    logic [31:0] adr_q;
    logic [31:0] dat_q;
    logic [3:0]  sel_q;
    logic [31:0] rdata_q;
    logic        start;

    assign start = mem_valid_i && !pending_q;

    always_ff @(posedge clk_core or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= 1'b0;
            cyc_q     <= 1'b0;
            ready_q   <= 1'b0;
        end else begin
            ready_q <= 1'b0;
            if (start) begin
                pending_q <= 1'b1;
                cyc_q     <= 1'b1;
            end else if (cyc_q && wb_rsp_i.ack) begin
                cyc_q   <= 1'b0;
                ready_q <= 1'b1;
            end else if (ready_q) begin
                pending_q <= 1'b0;  // core drops valid after ready
            end
        end
    end

    always_ff @(posedge clk_core) begin
        if (start) begin
            we_q  <= |mem_wstrb_i;
            adr_q <= mem_addr_i;
            dat_q <= mem_wdata_i;
            sel_q <= (|mem_wstrb_i) ? mem_wstrb_i : 4'hF;  // reads take the full word
        end
        if (cyc_q && wb_rsp_i.ack) begin
            rdata_q <= wb_rsp_i.dat;
        end
    end

    assign wb_req_o.cyc = cyc_q;
    assign wb_req_o.stb = cyc_q;
    assign wb_req_o.we  = we_q;
    assign wb_req_o.adr = adr_q;
    assign wb_req_o.dat = dat_q;
    assign wb_req_o.sel = sel_q;

    assign mem_ready_o = ready_q;
    assign mem_rdata_o = rdata_q;

endmodule

// ==== pci_pkg.sv ====
package pci_pkg;

    typedef enum logic [3:0] {
        OP_WRITE_MEM = 4'h1,
        OP_READ_MEM  = 4'h2,
        OP_RUN       = 4'h3,
        OP_HALT      = 4'h4,
        OP_READ_ID   = 4'h5
    } host_op_e;

    // Memory commands: word address in the low half
    typedef struct packed {
        host_op_e    op;
        logic [11:0] rsvd;
        logic [15:0] addr;
    } cmd_mem_t;

    // OP_RUN: release delay, zero selects the default
    typedef struct packed {
        host_op_e    op;
        logic [27:0] cycles;
    } cmd_ctrl_t;

    typedef union packed {
        cmd_mem_t  mem;
        cmd_ctrl_t ctrl;
    } cmd_word_u;

    typedef struct packed {
        cmd_word_u   word;
        logic [31:0] data;
    } host_cmd_t;

    typedef enum logic [1:0] {
        ST_OK     = 2'd0,
        ST_BUSY   = 2'd1,  // memory op while the core runs
        ST_BAD_OP = 2'd2
    } host_status_e;

    typedef struct packed {
        logic [31:0]  data;
        host_status_e status;
    } host_rsp_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;  // byte address
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

// ==== pci_settings.svh ====
`ifndef PCI_SETTINGS_SVH
`define PCI_SETTINGS_SVH

// Program memory depth in 32-bit words
`define PCI_MEM_WORDS 1024

// Cycles from OP_RUN to core reset release, used when the command count is zero
`define PCI_RESET_CYCLES 16

// Value returned by OP_READ_ID
`define PCI_ID 32'h5043_4931

`endif

// ==== processorci_top.sv ====
`timescale 1ns/10ps

module processorci_top (
    input  logic               clk_core,
    input  logic               arst_n_i,
    input  logic               host_req_i,
    input  pci_pkg::host_cmd_t host_cmd_i,
    input  logic               mem_valid_i,
    input  logic [31:0]        mem_addr_i,
    input  logic [31:0]        mem_wdata_i,
    input  logic [3:0]         mem_wstrb_i,
    output logic               host_ack_o,
    output pci_pkg::host_rsp_t host_rsp_o,
    output logic               core_rst_o,
    output logic               mem_ready_o,
    output logic [31:0]        mem_rdata_o
);
    import pci_pkg::*;

    logic        run_pulse;
    logic [27:0] run_cycles;
    logic        halt_pulse;
    logic        core_run;
    logic [31:0] harness_id;
    wb_req_t     host_wb_req;
    wb_rsp_t     host_wb_rsp;
    wb_req_t     core_wb_req;
    wb_rsp_t     core_wb_rsp;

    host_link u_host_link (
        .clk_core     (clk_core),
        .arst_n_i     (arst_n_i),
        .host_req_i   (host_req_i),
        .host_cmd_i   (host_cmd_i),
        .core_run_i   (core_run),
        .harness_id_i (harness_id),
        .wb_rsp_i     (host_wb_rsp),
        .host_ack_o   (host_ack_o),
        .host_rsp_o   (host_rsp_o),
        .run_pulse_o  (run_pulse),
        .run_cycles_o (run_cycles),
        .halt_pulse_o (halt_pulse),
        .wb_req_o     (host_wb_req)
    );

    ctrl_regs u_ctrl_regs (
        .clk_core     (clk_core),
        .arst_n_i     (arst_n_i),
        .run_pulse_i  (run_pulse),
        .run_cycles_i (run_cycles),
        .halt_pulse_i (halt_pulse),
        .core_run_o   (core_run),
        .core_rst_o   (core_rst_o),
        .harness_id_o (harness_id)
    );

    // Core side, native port to Wishbone
    native_to_wb u_native_to_wb (
        .clk_core    (clk_core),
        .arst_n_i    (arst_n_i),
        .mem_valid_i (mem_valid_i),
        .mem_addr_i  (mem_addr_i),
        .mem_wdata_i (mem_wdata_i),
        .mem_wstrb_i (mem_wstrb_i),
        .wb_rsp_i    (core_wb_rsp),
        .mem_ready_o (mem_ready_o),
        .mem_rdata_o (mem_rdata_o),
        .wb_req_o    (core_wb_req)
    );

    wb_memory u_wb_memory (
        .clk_core   (clk_core),
        .arst_n_i   (arst_n_i),
        .core_sel_i (core_run),  // core owns memory while running
        .host_req_i (host_wb_req),
        .core_req_i (core_wb_req),
        .host_rsp_o (host_wb_rsp),
        .core_rsp_o (core_wb_rsp)
    );

endmodule

// ==== sources.f ====
+incdir+.
pci_pkg.sv
host_link.sv
ctrl_regs.sv
native_to_wb.sv
wb_memory.sv
processorci_top.sv
tb_checker.sv
tb_processorci_properties.sv
tb_processorci.sv

// ==== tb_checker.sv ====
`timescale 1ns/10ps

`include "pci_settings.svh"

module tb_checker (
    input  logic               clk_core,
    input  logic               arst_n_i,
    input  logic               host_req_i,
    input  pci_pkg::host_cmd_t host_cmd_i,
    input  logic               host_ack_i,
    input  pci_pkg::host_rsp_t host_rsp_i,
    input  logic               core_rst_i,
    input  logic               mem_valid_i,
    input  logic [31:0]        mem_addr_i,
    input  logic [31:0]        mem_wdata_i,
    input  logic [3:0]         mem_wstrb_i,
    input  logic               mem_ready_i,
    input  logic [31:0]        mem_rdata_i,
    output int                 err_cnt_o,
    output int                 chk_cnt_o
);
    import pci_pkg::*;

    localparam int DEPTH = `PCI_MEM_WORDS;

    logic [31:0]  model_mem [DEPTH];
    host_cmd_t    cmd_q;
    logic         req_prev, ack_prev, after_rst;
    logic         run_q, armed, halting;   // model run state
    int           arm_wait, exp_delay, halt_wait;
    logic         core_busy, core_early;
    int           core_cycles, idx;
    logic [31:0]  core_addr, core_wdata, exp_data;
    logic [3:0]   core_strb;
    host_status_e exp_st;

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        chk_cnt_o++;
        if (got !== exp) begin
            err_cnt_o++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic flag(input string what);
        err_cnt_o++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    initial begin
        err_cnt_o = 0;
        chk_cnt_o = 0;
    end

    // Inputs change 1 ns after the rising edge, so sample on the falling edge
    always @(negedge clk_core) begin
        if (!arst_n_i) begin
            req_prev  = 1'b0;
            ack_prev  = 1'b0;
            run_q     = 1'b0;
            armed     = 1'b0;
            halting   = 1'b0;
            core_busy = 1'b0;
            after_rst = 1'b1;
        end else begin
            if (after_rst) begin  // state right after reset
                check_val("core_rst_o", {31'h0, core_rst_i}, 32'h1);
                check_val("host_ack_o", {31'h0, host_ack_i}, 32'h0);
                check_val("mem_ready_o", {31'h0, mem_ready_i}, 32'h0);
                after_rst = 1'b0;
            end
            // Run state
            if (armed) begin
                arm_wait++;
                if (!core_rst_i) begin
                    check_val("run delay", 32'(arm_wait), 32'(exp_delay));
                    armed = 1'b0;
                    run_q = 1'b1;
                end
            end else if (!core_rst_i && !run_q) begin
                flag("core reset released without OP_RUN");
                run_q = 1'b1;
            end
            if (halting) begin
                halt_wait++;
                if (core_rst_i) begin
                    check_val("halt delay", 32'(halt_wait), 32'd1);
                    halting = 1'b0;
                    run_q   = 1'b0;
                end
            end else if (core_rst_i && run_q) begin
                flag("core reset raised without OP_HALT");
                run_q = 1'b0;
            end
            // Host side
            if (host_req_i && !req_prev) cmd_q = host_cmd_i;
            if (host_ack_i && !ack_prev) begin
                exp_data = 32'h0;
                exp_st   = ST_OK;
                idx      = int'(cmd_q.word.mem.addr) % DEPTH;
                case (cmd_q.word.mem.op)
                    OP_WRITE_MEM: begin
                        if (run_q) exp_st = ST_BUSY;
                        else model_mem[idx] = cmd_q.data;
                    end
                    OP_READ_MEM: begin
                        if (run_q) exp_st = ST_BUSY;
                        else exp_data = model_mem[idx];
                    end
                    OP_RUN: begin
                        armed     = 1'b1;
                        arm_wait  = 0;
                        exp_delay = (cmd_q.word.ctrl.cycles == 28'h0) ?
                                    `PCI_RESET_CYCLES : int'(cmd_q.word.ctrl.cycles);
                        exp_delay++;  // Pulse reaches ctrl_regs one cycle after ack
                    end
                    OP_HALT: begin
                        halting   = 1'b1;
                        halt_wait = 0;
                    end
                    OP_READ_ID: exp_data = `PCI_ID;
                    default:    exp_st = ST_BAD_OP;
                endcase
                check_val("host_rsp_o.data", host_rsp_i.data, exp_data);
                check_val("host_rsp_o.status", {30'h0, host_rsp_i.status}, {30'h0, exp_st});
            end
            req_prev = host_req_i;
            ack_prev = host_ack_i;
            // Core side
            if (core_busy) core_cycles++;
            if (mem_ready_i) begin
                if (!core_busy) begin
                    flag("mem_ready_o without an open core access");
                end else begin
                    idx = int'(core_addr[31:2]) % DEPTH;
                    if (!core_early) check_val("core access cycles", 32'(core_cycles), 32'd3);
                    if (core_strb == 4'h0) begin
                        check_val("mem_rdata_o", mem_rdata_i, model_mem[idx]);
                    end else begin
                        for (int b = 0; b < 4; b++) begin
                            if (core_strb[b]) model_mem[idx][8*b +: 8] = core_wdata[8*b +: 8];
                        end
                    end
                    core_busy = 1'b0;
                end
            end else if (mem_valid_i && !core_busy) begin
                core_busy   = 1'b1;
                core_cycles = 0;
                core_early  = core_rst_i;  // issued before release, no fixed latency
                core_addr   = mem_addr_i;
                core_wdata  = mem_wdata_i;
                core_strb   = mem_wstrb_i;
            end
        end
    end

endmodule

// ==== tb_processorci.sv ====
`timescale 1ns/10ps

module tb_processorci;
    import pci_pkg::*;

    localparam int TIMEOUT = 200;

    logic        clk_core = 1'b0;
    logic        arst_n_i;
    logic        host_req_i;
    host_cmd_t   host_cmd_i;
    logic        mem_valid_i;
    logic [31:0] mem_addr_i;
    logic [31:0] mem_wdata_i;
    logic [3:0]  mem_wstrb_i;
    logic        host_ack_o;
    host_rsp_t   host_rsp_o;
    logic        core_rst_o;
    logic        mem_ready_o;
    logic [31:0] mem_rdata_o;
    int          err_cnt, chk_cnt, err_mark, test_cnt, test_fail;
    logic [15:0] addr_q [$];  // host word addresses holding known data

    always #5 clk_core = ~clk_core;

    processorci_top uut (.*);

    tb_checker chk (
        .clk_core    (clk_core),
        .arst_n_i    (arst_n_i),
        .host_req_i  (host_req_i),
        .host_cmd_i  (host_cmd_i),
        .host_ack_i  (host_ack_o),
        .host_rsp_i  (host_rsp_o),
        .core_rst_i  (core_rst_o),
        .mem_valid_i (mem_valid_i),
        .mem_addr_i  (mem_addr_i),
        .mem_wdata_i (mem_wdata_i),
        .mem_wstrb_i (mem_wstrb_i),
        .mem_ready_i (mem_ready_o),
        .mem_rdata_i (mem_rdata_o),
        .err_cnt_o   (err_cnt),
        .chk_cnt_o   (chk_cnt)
    );

    function automatic logic [31:0] mem_word(input logic [3:0] op, input logic [15:0] addr);
        return {op, 12'h0, addr};
    endfunction

    task automatic abort_run(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    // Four-phase transfer, returns once ack has dropped
    task automatic host_xfer(input logic [31:0] word, input logic [31:0] data);
        int n;
        host_cmd_i.word = word;
        host_cmd_i.data = data;
        host_req_i      = 1'b1;
        n = 0;
        do begin
            @(posedge clk_core);
            #1;
            n++;
            if (n > TIMEOUT) abort_run("host ack never rose");
        end while (!host_ack_o);
        host_req_i = 1'b0;
        n = 0;
        do begin
            @(posedge clk_core);
            #1;
            n++;
            if (n > TIMEOUT) abort_run("host ack never fell");
        end while (host_ack_o);
    endtask

    task automatic core_xfer(input logic [15:0] waddr, input logic [31:0] data,
                             input logic [3:0] strb);
        int          n;
        logic [31:0] upper;
        upper       = $urandom;
        mem_addr_i  = {upper[31:12], waddr[9:0], 2'b00};  // upper bits wrap
        mem_wdata_i = data;
        mem_wstrb_i = strb;
        mem_valid_i = 1'b1;
        n = 0;
        do begin
            @(posedge clk_core);
            #1;
            n++;
            if (n > TIMEOUT) abort_run("mem_ready_o never rose");
        end while (!mem_ready_o);
        mem_valid_i = 1'b0;
        mem_wstrb_i = 4'h0;
    endtask

    task automatic wait_core_rst(input logic level);
        int n;
        n = 0;
        while (core_rst_o !== level) begin
            @(posedge clk_core);
            #1;
            n++;
            if (n > TIMEOUT) abort_run("core_rst_o did not reach the expected level");
        end
    endtask

    task automatic report_test(input string name);
        test_cnt++;
        if (err_cnt != err_mark) begin
            test_fail++;
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
        end else begin
            $display("test %0d %s: ok", test_cnt, name);
        end
        err_mark = err_cnt;
    endtask

    initial begin
        logic [31:0] r, d;
        logic [15:0] a;
        void'($urandom(32'h742));
        arst_n_i    = 1'b0;
        host_req_i  = 1'b0;
        host_cmd_i  = '0;
        mem_valid_i = 1'b0;
        mem_addr_i  = 32'h0;
        mem_wdata_i = 32'h0;
        mem_wstrb_i = 4'h0;
        repeat (5) @(posedge clk_core);
        #1 arst_n_i = 1'b1;
        @(posedge clk_core);
        #1;

        for (int i = 0; i < 24; i++) begin
            r = $urandom;
            a = (i < 16) ? r[15:0] : addr_q[r[31:16] % 16];  // later ones overwrite
            if (i < 16) addr_q.push_back(a);
            host_xfer(mem_word(OP_WRITE_MEM, a), $urandom);
        end
        for (int i = 0; i < 24; i++) begin
            r = $urandom;
            host_xfer(mem_word(OP_READ_MEM, addr_q[r % 16]), 32'h0);
        end
        host_xfer(mem_word(OP_READ_ID, 16'h0), 32'h0);
        report_test("host write/read");

        for (int i = 0; i < 4; i++) begin
            r = $urandom;
            host_xfer(mem_word((i == 0) ? 4'h0 : 4'(6 + r % 10), addr_q[i]), $urandom);
            host_xfer(mem_word(OP_READ_MEM, addr_q[i]), 32'h0);
        end
        report_test("bad opcode");

        r = $urandom;
        host_xfer({OP_RUN, 28'(4 + r % 12)}, 32'h0);
        core_xfer(addr_q[r[19:16]], 32'h0, 4'h0);  // waits out the release delay
        wait_core_rst(1'b0);
        report_test("run release");

        fork
            for (int i = 0; i < 30; i++) begin
                r = $urandom;
                d = $urandom;
                core_xfer(addr_q[r[19:16]], d, r[0] ? r[7:4] : 4'h0);
                @(posedge clk_core);
                #1;
            end
            for (int i = 0; i < 6; i++) begin
                r = $urandom;
                host_xfer(mem_word(r[0] ? OP_WRITE_MEM : OP_READ_MEM, addr_q[r[7:4]]), $urandom);
            end
        join
        report_test("core access");

        host_xfer(mem_word(OP_HALT, 16'h0), 32'h0);
        wait_core_rst(1'b1);
        for (int i = 0; i < 16; i++) begin
            host_xfer(mem_word(OP_READ_MEM, addr_q[i]), 32'h0);
        end
        report_test("halt readback");

        repeat (2) @(posedge clk_core);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_cnt, test_fail, chk_cnt, err_cnt);
        if (err_cnt == 0 && test_fail == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== tb_processorci_properties.sv ====
`timescale 1ns/10ps

module tb_processorci_properties (
    input logic clk_core,
    input logic arst_n_i,
    input logic host_req_i,
    input logic host_ack_i,
    input logic mem_ready_i,
    input logic core_rst_i
);

    // Ack may only rise while the host is requesting
    ack_needs_req: assert property (@(posedge clk_core) disable iff (!arst_n_i)
        $rose(host_ack_i) |-> $past(host_req_i))
        else $error("host ack rose without a request");

    // Host may only drop req once ack is up
    req_held: assert property (@(posedge clk_core) disable iff (!arst_n_i)
        $fell(host_req_i) |-> host_ack_i)
        else $error("host req dropped before ack");

    ready_pulse: assert property (@(posedge clk_core) disable iff (!arst_n_i)
        mem_ready_i |=> !mem_ready_i)
        else $error("mem_ready_o longer than one cycle");

    no_ready_in_reset: assert property (@(posedge clk_core) disable iff (!arst_n_i)
        !(core_rst_i && mem_ready_i))
        else $error("mem_ready_o high while core is in reset");

endmodule

bind processorci_top tb_processorci_properties u_props (
    .clk_core    (clk_core),
    .arst_n_i    (arst_n_i),
    .host_req_i  (host_req_i),
    .host_ack_i  (host_ack_o),
    .mem_ready_i (mem_ready_o),
    .core_rst_i  (core_rst_o)
);

// ==== wb_memory.sv ====
`timescale 1ns/10ps

`include "pci_settings.svh"

module wb_memory (
    input  logic             clk_core,
    input  logic             arst_n_i,
    input  logic             core_sel_i,
    input  pci_pkg::wb_req_t host_req_i,
    input  pci_pkg::wb_req_t core_req_i,
    output pci_pkg::wb_rsp_t host_rsp_o,
    output pci_pkg::wb_rsp_t core_rsp_o
);
    import pci_pkg::*;

    localparam int AW = $clog2(`PCI_MEM_WORDS);

    logic [31:0]   mem_q [`PCI_MEM_WORDS];
    wb_req_t       req;
    logic [AW-1:0] word_addr;
    logic          hit;
    logic          ack_q;
    logic          side_q;   // 1 when the pending ack belongs to the core
    logic [31:0]   rdata_q;

    assign req       = core_sel_i ? core_req_i : host_req_i;
    assign word_addr = req.adr[AW+1:2];  // upper bits dropped, address wraps
    // No new access in the ack cycle, the master still holds its strobe
    assign hit       = req.cyc && req.stb && !ack_q;

    always_ff @(posedge clk_core or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q  <= 1'b0;
            side_q <= 1'b0;
        end else begin
            ack_q <= hit;
            if (hit) begin
                side_q <= core_sel_i;
            end
        end
    end

    always_ff @(posedge clk_core) begin
        if (hit) begin
            if (req.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.sel[b]) begin
                        mem_q[word_addr][8*b +: 8] <= req.dat[8*b +: 8];
                    end
                end
            end
            rdata_q <= mem_q[word_addr];
        end
    end

    // Only the side that issued the access sees the ack
    assign host_rsp_o.ack = ack_q && !side_q;
    assign host_rsp_o.dat = rdata_q;
    assign core_rsp_o.ack = ack_q && side_q;
    assign core_rsp_o.dat = rdata_q;

endmodule
